/* Bender.yml */
package:
  name: rx_subsystem

sources:
  - bus_pkg.sv
  - link_pkg.sv
  - crc16_engine.sv
  - link_rx.sv
  - buffer_arbiter.sv
  - packet_ram.sv
  - axil_host_port.sv
  - rx_subsystem_top.sv
  - target: test
    files:
      - tb_rx_subsystem.sv

/* axil_host_port.sv */
// AXI4-Lite slave with one transaction at a time, write wins over a read arriving together
// whole-word writes only, wstrb is not supported and low address bits are not checked in the window
`timescale 1ns/1ps

module axil_host_port
  import bus_pkg::*;
#(
  parameter int WORDS_PER_PKT = 8
) (
  input  logic      clock,
  input  logic      arst_n,
  input  axil_req_t axil_req,
  input  logic      pub_bank,
  input  data_t     good_count,
  input  data_t     err_count,
  input  logic      host_rd_grant,
  input  data_t     host_rd_data,
  output axil_rsp_t axil_rsp,
  output logic      skip_crc,
  output logic      host_rd_valid,
  output ram_addr_t host_rd_addr
);

  localparam int         WIDX    = $clog2(WORDS_PER_PKT);
  localparam axil_addr_t win_end = win_base + axil_addr_t'(4 * WORDS_PER_PKT);

  typedef enum logic [2:0] {
    hp_idle,      // waiting for a request, ready pulses are raised here
    hp_wr_resp,   // bvalid held until bready
    hp_reg_rd,    // one cycle to select the register
    hp_win_wait,  // RAM read outstanding in the arbiter
    hp_rd_resp    // rvalid held until rready
  } hp_state_e;

  hp_state_e  state;
  logic       wr_ready;    // drives awready and wready together
  logic       arready;
  logic       bvalid;
  logic       rvalid;
  axil_resp_e bresp;
  axil_resp_e rresp;
  data_t      rdata;
  axil_addr_t rd_addr;     // latched read address
  axil_addr_t win_off;
  logic       ar_in_win;

  assign ar_in_win = (axil_req.araddr >= win_base) && (axil_req.araddr < win_end);
  assign win_off   = rd_addr - win_base;

  // byte offset to word index, placed in whatever bank is published right now
  assign host_rd_addr  = ram_addr_t'({pub_bank, win_off[WIDX+1:2]});
  assign host_rd_valid = (state == hp_win_wait);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state    <= hp_idle;
      wr_ready <= 1'b0;
      arready  <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
      skip_crc <= 1'b0;
      bresp    <= resp_okay;
      rresp    <= resp_okay;
      rdata    <= '0;
      rd_addr  <= '0;
    end else begin
      case (state)
        hp_idle: begin
          if (wr_ready) begin
            // the master held both valids, so the handshake completes on this edge
            wr_ready <= 1'b0;
            bvalid   <= 1'b1;
            state    <= hp_wr_resp;
            if (axil_req.awaddr == reg_control) begin
              skip_crc <= axil_req.wdata[0];
              bresp    <= resp_okay;
            end else begin
              bresp <= resp_slverr;  // counters and bank are read only
            end
          end else if (arready) begin
            arready <= 1'b0;
            rd_addr <= axil_req.araddr;
            state   <= ar_in_win ? hp_win_wait : hp_reg_rd;
          end else if (axil_req.awvalid && axil_req.wvalid) begin
            wr_ready <= 1'b1;  // write checked first
          end else if (axil_req.arvalid) begin
            arready <= 1'b1;
          end
        end
        hp_wr_resp: begin
          if (axil_req.bready) begin
            bvalid <= 1'b0;
            state  <= hp_idle;
          end
        end
        hp_reg_rd: begin
          rvalid <= 1'b1;
          state  <= hp_rd_resp;
          rresp  <= resp_okay;
          case (rd_addr)
            reg_good_count: rdata <= good_count;
            reg_err_count:  rdata <= err_count;
            reg_control:    rdata <= {31'd0, skip_crc};
            reg_bank:       rdata <= {31'd0, pub_bank};
            default: begin
              rdata <= '0;  // unmapped, data zero with an error
              rresp <= resp_slverr;
            end
          endcase
        end
        hp_win_wait: begin
          if (host_rd_grant) begin
            rdata  <= host_rd_data;
            rresp  <= resp_okay;
            rvalid <= 1'b1;
            state  <= hp_rd_resp;
          end
        end
        hp_rd_resp: begin
          if (axil_req.rready) begin
            rvalid <= 1'b0;
            state  <= hp_idle;
          end
        end
        default: state <= hp_idle;
      endcase
    end
  end

  always_comb begin
    axil_rsp.awready = wr_ready;
    axil_rsp.wready  = wr_ready;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = bresp;
    axil_rsp.arready = arready;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
  end

endmodule

/* buffer_arbiter.sv */
// one RAM port shared by receiver writes and host reads, the receiver always wins
// only one host read may be in flight, its data returns with host_rd_grant
`timescale 1ns/1ps

module buffer_arbiter
  import link_pkg::*, bus_pkg::*;
#(
  parameter int WORDS_PER_PKT = 8
) (
  input  logic      clock,
  input  logic      arst_n,
  input  rx_wr_t    rx_wr,
  input  logic      host_rd_valid,  // held until host_rd_grant
  input  ram_addr_t host_rd_addr,
  input  data_t     ram_rdata,
  output logic      host_rd_grant,  // pulse, host_rd_data is valid in this cycle
  output data_t     host_rd_data,
  output ram_req_t  ram_req
);

  // keeps every RAM access inside the two banks of this build
  localparam ram_addr_t addr_mask = ram_addr_t'(2 * WORDS_PER_PKT - 1);

  logic rd_issue;  // host read goes to the RAM this cycle
  logic rd_q;      // a read was issued last cycle, data is on ram_rdata now

  // a pending return also blocks a reissue while the host still holds valid
  assign rd_issue = host_rd_valid && !rx_wr.valid && !rd_q;

  always_comb begin
    ram_req = '0;
    if (rx_wr.valid) begin
      ram_req.valid = 1'b1;
      ram_req.write = 1'b1;
      ram_req.addr  = rx_wr.addr & addr_mask;
      ram_req.data  = rx_wr.data;
    end else if (rd_issue) begin
      ram_req.valid = 1'b1;
      ram_req.addr  = host_rd_addr & addr_mask;  // read, data field stays zero
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd_issue;
    end
  end

  assign host_rd_grant = rd_q;
  assign host_rd_data  = rd_q ? ram_rdata : '0;  // only the host's own read reaches it

endmodule

/* bus_pkg.sv */
// host side definitions: AXI4-Lite channels, register map and the shared RAM port
// the RAM address type is sized for the largest build, 64 words per packet in two banks
package bus_pkg;

  typedef logic [31:0] data_t;       // one AXI data word, also one RAM word
  typedef logic [11:0] axil_addr_t;  // byte address seen on the host bus
  typedef logic [6:0]  ram_addr_t;   // covers 2 x 64 words, smaller builds use the low bits

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    data_t      wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_e bresp;
    logic       arready;
    logic       rvalid;
    data_t      rdata;
    axil_resp_e rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic      valid;
    logic      write;  // 0 means read
    ram_addr_t addr;
    data_t     data;   // ignored on reads
  } ram_req_t;

  localparam axil_addr_t reg_good_count = 12'h000;  // read only
  localparam axil_addr_t reg_err_count  = 12'h004;  // read only
  localparam axil_addr_t reg_control    = 12'h008;  // bit 0 is skip_crc
  localparam axil_addr_t reg_bank       = 12'h00C;  // published bank index
  localparam axil_addr_t win_base       = 12'h100;  // first word of the packet window

endpackage

/* crc16_engine.sv */
// CRC-16-CCITT over whole bytes, msb of each byte first into the register
// init wins over ena when both are high
`timescale 1ns/1ps

module crc16_engine
  import link_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       init,       // reload the start value
  input  logic       ena,        // fold data_byte in on this edge
  input  logic [7:0] data_byte,
  output crc_t       crc
);

  // one byte step of the serial shift register, unrolled over 8 bits
  function automatic crc_t crc_step(crc_t cur, logic [7:0] b);
    crc_t r;
    r = cur ^ {b, 8'h00};  // byte enters at the top of the register
    for (int i = 0; i < 8; i++) begin
      r = r[15] ? ((r << 1) ^ crc_poly) : (r << 1);  // feedback on the bit shifted out
    end
    return r;
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      crc <= crc_init;
    end else if (init) begin
      crc <= crc_init;  // held here for the whole hunt phase
    end else if (ena) begin
      crc <= crc_step(crc, data_byte);
    end
  end

endmodule

/* link_pkg.sv */
// serial link framing constants and receiver types
// the word-write struct reuses the RAM address and data types of the bus package
package link_pkg;

  import bus_pkg::*;

  typedef logic [15:0] crc_t;

  localparam logic [31:0] sync_word = 32'hAC450F28;  // framing pattern, sent lsb first
  localparam crc_t        crc_init  = 16'hFFFF;      // CCITT start value
  localparam crc_t        crc_poly  = 16'h1021;      // x^16 + x^12 + x^5 + 1

  typedef enum logic [1:0] {
    rx_hunt = 2'd0,  // searching for the sync word
    rx_data = 2'd1,  // collecting data words
    rx_crc  = 2'd2   // collecting and checking the trailing crc
  } rx_state_e;

  typedef struct packed {
    logic      valid;
    ram_addr_t addr;  // hidden bank times words per packet plus word index
    data_t     data;
  } rx_wr_t;

endpackage

/* link_rx.sv */
// serial receiver, one bit per rising edge lsb first, fixed 32 cycles per word
// needs at least a couple of idle bits between packets since the window is cleared after the crc
`timescale 1ns/1ps

module link_rx
  import link_pkg::*, bus_pkg::*;
#(
  parameter int WORDS_PER_PKT = 8
) (
  input  logic   clock,
  input  logic   arst_n,
  input  logic   rdat,        // serial data in
  input  logic   skip_crc,    // publish even on a crc mismatch
  output rx_wr_t rx_wr,       // one word write per 32 bits, never stalls
  output logic   pub_bank,    // bank the host may read
  output data_t  good_count,
  output data_t  err_count
);

  localparam int WIDX = $clog2(WORDS_PER_PKT);

  rx_state_e        state;
  logic [31:0]      shreg;       // right shifting window, newest bit at the top
  logic [31:0]      shreg_next;
  logic [4:0]       bit_cnt;     // bit inside the word, or inside the crc tail
  logic [WIDX-1:0]  word_idx;
  logic             load_crc;    // a full byte sits in shreg[31:24]
  logic             crc_ok;      // registered compare result
  crc_t             crc_calc;

  assign shreg_next = {rdat, shreg[31:1]};  // lsb first on the wire

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      shreg <= '0;
    end else if (state == rx_crc && bit_cnt == 5'd17) begin
      shreg <= '0;  // no stale sync match on return to hunt
    end else begin
      shreg <= shreg_next;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= rx_hunt;
      bit_cnt    <= '0;
      word_idx   <= '0;
      load_crc   <= 1'b0;
      crc_ok     <= 1'b0;
      rx_wr      <= '0;
      pub_bank   <= 1'b0;
      good_count <= '0;
      err_count  <= '0;
    end else begin
      rx_wr.valid <= 1'b0;  // write strobe lasts one cycle
      load_crc    <= 1'b0;
      case (state)
        rx_hunt: begin
          // compare the window including this edge's bit so the next edge is data bit 0
          if (shreg_next == sync_word) begin
            state    <= rx_data;
            bit_cnt  <= '0;
            word_idx <= '0;
          end
        end
        rx_data: begin
          load_crc <= (bit_cnt[2:0] == 3'd7);  // byte completes on this edge
          bit_cnt  <= bit_cnt + 5'd1;          // wraps to 0 after bit 31
          if (bit_cnt == 5'd31) begin
            rx_wr.valid <= 1'b1;
            rx_wr.addr  <= ram_addr_t'({~pub_bank, word_idx});  // always the hidden bank
            rx_wr.data  <= shreg_next;
            word_idx    <= word_idx + 1'b1;
            if (word_idx == WIDX'(WORDS_PER_PKT - 1)) begin
              state <= rx_crc;  // the last byte is still folded in on the next edge
            end
          end
        end
        rx_crc: begin
          bit_cnt <= bit_cnt + 5'd1;
          if (bit_cnt == 5'd16) begin
            // all 16 crc bits were sampled by the previous edge
            crc_ok <= skip_crc || (shreg[31:16] == crc_calc);
          end
          if (bit_cnt == 5'd17) begin
            state   <= rx_hunt;
            bit_cnt <= '0;
            if (crc_ok) begin
              pub_bank   <= ~pub_bank;  // hidden bank becomes visible
              good_count <= good_count + 32'd1;
            end else begin
              err_count <= err_count + 32'd1;  // bank stays, next packet overwrites hidden
            end
          end
        end
        default: state <= rx_hunt;
      endcase
    end
  end

  crc16_engine u_crc (
    .clock     (clock),
    .arst_n    (arst_n),
    .init      (state == rx_hunt),
    .ena       (load_crc),
    .data_byte (shreg[31:24]),
    .crc       (crc_calc)
  );

endmodule

/* packet_ram.sv */
// single port RAM for two packet banks, read data is registered and held between reads
`timescale 1ns/1ps

module packet_ram
  import bus_pkg::*;
#(
  parameter int WORDS_PER_PKT = 8
) (
  input  logic     clock,
  input  ram_req_t ram_req,
  output data_t    ram_rdata
);

  localparam int DEPTH = 2 * WORDS_PER_PKT;
  localparam int AW    = $clog2(DEPTH);

  data_t mem [DEPTH];

  always_ff @(posedge clock) begin
    if (ram_req.valid) begin
      if (ram_req.write) begin
        mem[ram_req.addr[AW-1:0]] <= ram_req.data;
      end else begin
        ram_rdata <= mem[ram_req.addr[AW-1:0]];  // unchanged by writes in between
      end
    end
  end

endmodule

/* rx_subsystem_top.sv */
// serial link receiver with a double buffered packet RAM read over AXI4-Lite
// WORDS_PER_PKT must be a power of two from 4 to 64
`timescale 1ns/1ps

module rx_subsystem_top
  import link_pkg::*, bus_pkg::*;
#(
  parameter int WORDS_PER_PKT = 8
) (
  input  logic      clock,
  input  logic      arst_n,
  input  logic      rdat,      // serial link, sampled on every rising edge
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp
);

  rx_wr_t    rx_wr;
  logic      pub_bank;
  data_t     good_count;
  data_t     err_count;
  logic      skip_crc;
  logic      host_rd_valid;
  ram_addr_t host_rd_addr;
  logic      host_rd_grant;
  data_t     host_rd_data;
  ram_req_t  ram_req;
  data_t     ram_rdata;

  link_rx #(.WORDS_PER_PKT(WORDS_PER_PKT)) u_link_rx (
    .clock      (clock),
    .arst_n     (arst_n),
    .rdat       (rdat),
    .skip_crc   (skip_crc),
    .rx_wr      (rx_wr),
    .pub_bank   (pub_bank),
    .good_count (good_count),
    .err_count  (err_count)
  );

  buffer_arbiter #(.WORDS_PER_PKT(WORDS_PER_PKT)) u_arbiter (
    .clock         (clock),
    .arst_n        (arst_n),
    .rx_wr         (rx_wr),
    .host_rd_valid (host_rd_valid),
    .host_rd_addr  (host_rd_addr),
    .ram_rdata     (ram_rdata),
    .host_rd_grant (host_rd_grant),
    .host_rd_data  (host_rd_data),
    .ram_req       (ram_req)
  );

  packet_ram #(.WORDS_PER_PKT(WORDS_PER_PKT)) u_ram (
    .clock     (clock),
    .ram_req   (ram_req),
    .ram_rdata (ram_rdata)
  );

  axil_host_port #(.WORDS_PER_PKT(WORDS_PER_PKT)) u_host_port (
    .clock         (clock),
    .arst_n        (arst_n),
    .axil_req      (axil_req),
    .pub_bank      (pub_bank),
    .good_count    (good_count),
    .err_count     (err_count),
    .host_rd_grant (host_rd_grant),
    .host_rd_data  (host_rd_data),
    .axil_rsp      (axil_rsp),
    .skip_crc      (skip_crc),
    .host_rd_valid (host_rd_valid),
    .host_rd_addr  (host_rd_addr)
  );

endmodule

/* sources.f */
bus_pkg.sv
link_pkg.sv
crc16_engine.sv
link_rx.sv
buffer_arbiter.sv
packet_ram.sv
axil_host_port.sv
rx_subsystem_top.sv
tb_rx_subsystem.sv

/* tb_rx_subsystem.sv */
// random packets from a fixed xorshift seed, checked against a reference model of the receiver
// one AXI transaction at a time, window reads also run while a packet streams in
`timescale 1ns/1ps

module tb_rx_subsystem
  import link_pkg::*, bus_pkg::*;
;

  localparam int WPP         = 8;
  localparam int CLK_PERIOD  = 4;
  localparam int NUM_CHECKED = 10;  // crc checked, about a quarter corrupted
  localparam int NUM_SKIPPED = 3;   // skip_crc set, all corrupted
  localparam int NUM_PKTS    = NUM_CHECKED + NUM_SKIPPED;
  localparam int MAX_IDLE    = 16;
  localparam int PKT_CYCLES  = MAX_IDLE + 32 * WPP + 48;
  localparam int WATCHDOG_NS = NUM_PKTS * PKT_CYCLES * CLK_PERIOD * 3 / 2;

  logic      clock;
  logic      arst_n;
  logic      rdat;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;

  logic [31:0] rng_state = 32'h7dbb;
  data_t       tx_words  [WPP];  // words of the packet being sent
  data_t       pub_words [WPP];  // words the host should see in the window
  logic        exp_bank;
  data_t       exp_good;
  data_t       exp_err;
  logic        have_pub;         // a good packet has been published, so the window is defined

  rx_subsystem_top #(.WORDS_PER_PKT(WPP)) dut (
    .clock    (clock),
    .arst_n   (arst_n),
    .rdat     (rdat),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // bit serial CCITT over the bytes of tx_words, low byte of each word first
  function automatic crc_t reference_crc();
    crc_t       c;
    logic [7:0] cur_byte;
    logic       fb;
    c = 16'hFFFF;
    for (int w = 0; w < WPP; w++) begin
      for (int j = 0; j < 4; j++) begin
        cur_byte = tx_words[w][8*j +: 8];
        for (int i = 7; i >= 0; i--) begin
          fb = c[15] ^ cur_byte[i];  // msb of the byte meets the register first
          c  = {c[14:0], 1'b0};
          if (fb) c = c ^ 16'h1021;
        end
      end
    end
    return c;
  endfunction

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "data check failed");
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "response check failed");
    end
  endtask

  task automatic axil_read(input axil_addr_t addr, output data_t data, output axil_resp_e resp);
    @(posedge clock);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    @(posedge clock);
    while (axil_rsp.arready !== 1'b1) @(posedge clock);
    axil_req.arvalid <= 1'b0;  // address accepted on this edge
    @(posedge clock);
    while (axil_rsp.rvalid !== 1'b1) @(posedge clock);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready <= 1'b0;
  endtask

  task automatic axil_write(input axil_addr_t addr, input data_t data, output axil_resp_e resp);
    @(posedge clock);
    axil_req.awaddr  <= addr;
    axil_req.wdata   <= data;
    axil_req.awvalid <= 1'b1;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    @(posedge clock);
    while (!(axil_rsp.awready === 1'b1 && axil_rsp.wready === 1'b1)) @(posedge clock);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(posedge clock);
    while (axil_rsp.bvalid !== 1'b1) @(posedge clock);
    resp = axil_rsp.bresp;
    axil_req.bready <= 1'b0;
  endtask

  task automatic read_expect(input axil_addr_t addr, input string name, input data_t exp);
    data_t      d;
    axil_resp_e r;
    axil_read(addr, d, r);
    check_resp({name, " rresp"}, r, resp_okay);
    check_word(name, d, exp);
  endtask

  task automatic check_status();
    read_expect(reg_good_count, "good_count", exp_good);
    read_expect(reg_err_count, "err_count", exp_err);
    read_expect(reg_bank, "pub_bank", {31'd0, exp_bank});
  endtask

  task automatic check_window();
    for (int i = 0; i < WPP; i++) begin
      read_expect(win_base + axil_addr_t'(4 * i), $sformatf("window word %0d", i), pub_words[i]);
    end
  endtask

  task automatic send_bit(input logic b);
    @(posedge clock);
    rdat <= b;
  endtask

  // idle zeros, sync, data words and crc, every field lsb first
  task automatic send_packet(input int idle, input crc_t crc);
    repeat (idle) send_bit(1'b0);
    for (int i = 0; i < 32; i++) send_bit(sync_word[i]);
    for (int w = 0; w < WPP; w++) begin
      for (int i = 0; i < 32; i++) send_bit(tx_words[w][i]);
    end
    for (int i = 0; i < 16; i++) send_bit(crc[i]);
    send_bit(1'b0);  // line back to idle
  endtask

  // starts 20 bits into the first data word, finishes long before the crc tail
  task automatic read_window_midstream(input int idle);
    repeat (idle + 52) @(posedge clock);
    check_window();
  endtask

  task automatic run_packet(input logic corrupt, input logic skip);
    int          idle;
    crc_t        crc;
    logic [31:0] rnd;
    for (int w = 0; w < WPP; w++) tx_words[w] = next_random();
    rnd  = next_random();
    idle = int'(rnd[3:0]);
    crc  = reference_crc();
    if (corrupt) begin
      rnd = next_random();
      crc[rnd[3:0]] = ~crc[rnd[3:0]];  // one flipped bit is always caught
    end
    fork
      send_packet(idle, crc);
      if (have_pub) read_window_midstream(idle);
    join
    repeat (4) @(posedge clock);  // swap lands two edges after the last crc bit
    if (!corrupt || skip) begin
      pub_words = tx_words;
      exp_bank  = ~exp_bank;
      exp_good  = exp_good + 32'd1;
      have_pub  = 1'b1;
    end else begin
      exp_err = exp_err + 32'd1;  // hidden bank was overwritten but stays hidden
    end
    check_status();
    if (have_pub) check_window();
  endtask

  initial begin
    data_t       d;
    axil_resp_e  r;
    logic [31:0] rnd;
    logic        corrupt;
    rdat     = 1'b0;
    axil_req = '0;
    arst_n   = 1'b0;
    exp_bank = 1'b0;
    exp_good = '0;
    exp_err  = '0;
    have_pub = 1'b0;
    repeat (5) @(posedge clock);
    arst_n <= 1'b1;
    repeat (2) @(posedge clock);

    check_status();  // counters and bank start at zero
    read_expect(reg_control, "control", 32'd0);

    axil_write(reg_good_count, 32'h0000_1234, r);
    check_resp("good_count bresp", r, resp_slverr);
    axil_read(12'h010, d, r);  // inside the register page but not mapped
    check_resp("unmapped rresp", r, resp_slverr);
    check_word("unmapped rdata", d, 32'd0);
    check_status();  // the refused write left good_count alone

    for (int p = 0; p < NUM_CHECKED; p++) begin
      rnd     = next_random();
      corrupt = (p == 2) || (p != 0 && rnd[1:0] == 2'b00);  // first good, third always bad
      run_packet(corrupt, 1'b0);
    end

    axil_write(reg_control, 32'd1, r);
    check_resp("control bresp", r, resp_okay);
    read_expect(reg_control, "control", 32'd1);
    for (int p = 0; p < NUM_SKIPPED; p++) begin
      run_packet(1'b1, 1'b1);  // bad crc but published
    end

    $display("TEST OK");
    $finish;
  end

endmodule
